/* hw/cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// ************************************************************
// unified memory geometry
// ************************************************************

// 16-bit words shared by code, data and host
`define MEM_DEPTH 256

// low address bits that index the array, log2 of depth
`define MEM_AW 8

`endif

/* hw/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef logic [15:0] word_t;     // data or instruction word
	typedef logic [15:0] addr_t;     // word address, arbiter wraps it
	typedef logic [3:0]  reg_idx_t;  // r0..r15

	// instr[15:12]
	typedef enum logic [3:0] {
		OP_ADD   = 4'h0,
		OP_SUB   = 4'h1,
		OP_AND   = 4'h2,
		OP_OR    = 4'h3,
		OP_XOR   = 4'h4,
		OP_SLL   = 4'h5,  // rs << rt[3:0]
		OP_SRL   = 4'h6,  // logical
		OP_NOP7  = 4'h7,
		OP_LW    = 4'h8,  // rd = mem[rs + imm4]
		OP_SW    = 4'h9,  // mem[rs + imm4] = rd
		OP_LHB   = 4'ha,
		OP_LLB   = 4'hb,
		OP_NOP12 = 4'hc,
		OP_NOP13 = 4'hd,
		OP_NOP14 = 4'he,
		OP_HLT   = 4'hf
	} opcode_t;

	// one handshake in flight at a time
	typedef enum logic [1:0] {ARB_IDLE, ARB_ACCESS, ARB_ACKED} arb_state_t;

	// peer owning the array, listed by priority
	typedef enum logic [1:0] {REQ_HOST, REQ_DATA, REQ_FETCH} requester_t;

endpackage

`default_nettype wire

/* hw/mem_if.sv */
`timescale 1ns/10ps
`default_nettype none

// four-phase req/ack memory port
interface mem_if;

	logic           req;    // held until ack seen
	logic           ack;    // held until req seen low
	logic           we;
	cpu_pkg::addr_t addr;
	cpu_pkg::word_t wdata;
	cpu_pkg::word_t rdata;  // valid while ack high

	// fetch path, load/store path, host
	modport requester (output req, output we, output addr, output wdata,
		input ack, input rdata);

	// arbiter side
	modport responder (input req, input we, input addr, input wdata,
		output ack, output rdata);

endinterface

`default_nettype wire

/* hw/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module mem_arbiter (
	input logic clk,
	input logic arst_n,
	mem_if.responder fetch_bus,
	mem_if.responder data_bus,
	mem_if.responder host_bus
);

	cpu_pkg::word_t mem [`MEM_DEPTH];  // instr + data, no reset
	cpu_pkg::arb_state_t state;
	cpu_pkg::requester_t grant;        // latched in idle
	cpu_pkg::word_t rdata_q;
	logic sel_req;
	logic sel_we;
	cpu_pkg::addr_t sel_addr;
	cpu_pkg::word_t sel_wdata;
	logic [`MEM_AW-1:0] idx;
	logic ack;

	// ************************************************************
	// mux of the granted peer
	// ************************************************************
	always_comb begin
		case (grant)
			cpu_pkg::REQ_HOST: begin
				sel_req   = host_bus.req;
				sel_we    = host_bus.we;
				sel_addr  = host_bus.addr;
				sel_wdata = host_bus.wdata;
			end
			cpu_pkg::REQ_DATA: begin
				sel_req   = data_bus.req;
				sel_we    = data_bus.we;
				sel_addr  = data_bus.addr;
				sel_wdata = data_bus.wdata;
			end
			default: begin
				sel_req   = fetch_bus.req;
				sel_we    = fetch_bus.we;   // always read
				sel_addr  = fetch_bus.addr;
				sel_wdata = fetch_bus.wdata;
			end
		endcase
	end

	assign idx = sel_addr[`MEM_AW-1:0];         // wraps modulo depth
	assign ack = (state == cpu_pkg::ARB_ACKED);

	// idle -> access -> acked -> idle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cpu_pkg::ARB_IDLE;
			grant <= cpu_pkg::REQ_FETCH;
		end else begin
			case (state)
				cpu_pkg::ARB_IDLE: begin
					// host first, fetch last
					if (host_bus.req) begin
						grant <= cpu_pkg::REQ_HOST;
						state <= cpu_pkg::ARB_ACCESS;
					end else if (data_bus.req) begin
						grant <= cpu_pkg::REQ_DATA;
						state <= cpu_pkg::ARB_ACCESS;
					end else if (fetch_bus.req) begin
						grant <= cpu_pkg::REQ_FETCH;
						state <= cpu_pkg::ARB_ACCESS;
					end
				end
				cpu_pkg::ARB_ACCESS: state <= cpu_pkg::ARB_ACKED;  // ack rises here
				cpu_pkg::ARB_ACKED: if (!sel_req) state <= cpu_pkg::ARB_IDLE;
				default: state <= cpu_pkg::ARB_IDLE;
			endcase
		end
	end

	// single array access per transaction
	always_ff @(posedge clk) begin
		if (state == cpu_pkg::ARB_ACCESS) begin
			if (sel_we)
				mem[idx] <= sel_wdata;
			rdata_q <= sel_we ? sel_wdata : mem[idx];  // echo on write
		end
	end

	// ack and data only to the owner
	assign host_bus.ack    = ack && (grant == cpu_pkg::REQ_HOST);
	assign data_bus.ack    = ack && (grant == cpu_pkg::REQ_DATA);
	assign fetch_bus.ack   = ack && (grant == cpu_pkg::REQ_FETCH);
	assign host_bus.rdata  = (grant == cpu_pkg::REQ_HOST) ? rdata_q : '0;
	assign data_bus.rdata  = (grant == cpu_pkg::REQ_DATA) ? rdata_q : '0;
	assign fetch_bus.rdata = (grant == cpu_pkg::REQ_FETCH) ? rdata_q : '0;

endmodule

`default_nettype wire

/* hw/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file (
	input  logic              clk,
	input  logic              arst_n,
	input  cpu_pkg::reg_idx_t rs_idx,
	input  cpu_pkg::reg_idx_t rt_idx,
	input  cpu_pkg::reg_idx_t rd_idx,   // SW, LHB, LLB source
	output cpu_pkg::word_t    rs_data,
	output cpu_pkg::word_t    rt_data,
	output cpu_pkg::word_t    rd_data,
	input  logic              wen,
	input  cpu_pkg::reg_idx_t wr_idx,
	input  cpu_pkg::word_t    wr_data
);

	cpu_pkg::word_t regs [16];  // r0 is a normal register

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wen) begin
			regs[wr_idx] <= wr_data;
		end
	end

	// write-through, WB result visible to ID same cycle
	assign rs_data = (wen && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
	assign rt_data = (wen && wr_idx == rt_idx) ? wr_data : regs[rt_idx];
	assign rd_data = (wen && wr_idx == rd_idx) ? wr_data : regs[rd_idx];

endmodule

`default_nettype wire

/* hw/hazard_detection.sv */
`timescale 1ns/10ps
`default_nettype none

module hazard_detection (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           advance,      // global pipeline step
	input  cpu_pkg::word_t if_id_instr,  // nop when IF/ID empty
	input  cpu_pkg::word_t id_ex_instr,
	input  logic           id_ex_valid,
	output logic           stall,
	output logic           hlt_seen,
	output logic           halted
);

	cpu_pkg::opcode_t id_op;
	cpu_pkg::opcode_t ex_op;
	logic use_rd, use_rs, use_rt;
	logic alu_op;
	logic hlt_id;
	logic [1:0] hlt_q;  // HLT in EX, then MEM

	// ************************************************************
	// load-use
	// ************************************************************
	assign id_op  = cpu_pkg::opcode_t'(if_id_instr[15:12]);
	assign ex_op  = cpu_pkg::opcode_t'(id_ex_instr[15:12]);
	assign alu_op = (if_id_instr[15:12] <= 4'h6);  // ADD..SRL

	// which fields of the IF/ID word are read
	assign use_rd = (id_op == cpu_pkg::OP_SW) || (id_op == cpu_pkg::OP_LHB)
		|| (id_op == cpu_pkg::OP_LLB);
	assign use_rs = alu_op || (id_op == cpu_pkg::OP_SW) || (id_op == cpu_pkg::OP_LW);
	assign use_rt = alu_op;

	assign stall = id_ex_valid && (ex_op == cpu_pkg::OP_LW) && (
		(use_rd && if_id_instr[11:8] == id_ex_instr[11:8]) ||
		(use_rs && if_id_instr[7:4] == id_ex_instr[11:8]) ||
		(use_rt && if_id_instr[3:0] == id_ex_instr[11:8]));

	// ************************************************************
	// HLT
	// ************************************************************
	assign hlt_id   = (id_op == cpu_pkg::OP_HLT);
	assign hlt_seen = hlt_id || (|hlt_q) || halted;  // keeps fetch shut while draining

	// third advance puts HLT in writeback
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hlt_q  <= '0;
			halted <= 1'b0;
		end else if (advance) begin
			hlt_q  <= {hlt_q[0], hlt_id};
			halted <= halted | hlt_q[1];  // sticky until reset
		end
	end

endmodule

`default_nettype wire

/* hw/cpu_pipeline.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_pipeline (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              run,
	input  logic              stall,
	input  logic              hlt_seen,
	mem_if.requester          fetch_bus,
	mem_if.requester          data_bus,
	output cpu_pkg::reg_idx_t rs_idx,
	output cpu_pkg::reg_idx_t rt_idx,
	output cpu_pkg::reg_idx_t rd_idx,
	input  cpu_pkg::word_t    rs_data,
	input  cpu_pkg::word_t    rt_data,
	input  cpu_pkg::word_t    rd_data,
	output logic              wen,
	output cpu_pkg::reg_idx_t wr_idx,
	output cpu_pkg::word_t    wr_data,
	output cpu_pkg::word_t    if_id_instr,
	output cpu_pkg::word_t    id_ex_instr,
	output logic              id_ex_valid,
	output logic              advance
);

	// per-requester handshake
	typedef enum logic [1:0] {HS_IDLE, HS_WAIT_ACK, HS_WAIT_DROP} hs_state_t;

	hs_state_t f_state;
	hs_state_t d_state;
	cpu_pkg::addr_t pc;
	logic if_valid;                // IF holds a fetched word
	cpu_pkg::word_t if_instr;
	logic fetch_go, fetch_pending;
	logic if_id_valid;
	cpu_pkg::word_t if_id_q;
	cpu_pkg::word_t id_ex_rs, id_ex_rt, id_ex_rd;
	cpu_pkg::opcode_t ex_op;
	cpu_pkg::word_t op_a, op_b, op_c;
	cpu_pkg::word_t ex_imm, ex_result;
	logic ex_wen;
	logic ex_mem_valid, ex_mem_wen, ex_mem_lw, ex_mem_sw;
	cpu_pkg::reg_idx_t ex_mem_rd;
	cpu_pkg::word_t ex_mem_result, ex_mem_store;
	cpu_pkg::word_t load_q;
	logic mem_go, data_pending;
	logic ex_mem_fwd, mem_wb_fwd;
	logic mem_wb_valid, mem_wb_wen;
	cpu_pkg::reg_idx_t mem_wb_rd;
	cpu_pkg::word_t mem_wb_result;

	// ************************************************************
	// IF, fetch requester
	// ************************************************************
	assign fetch_go = run && !hlt_seen && !if_valid;
	assign fetch_pending = (f_state == HS_IDLE && fetch_go) || (f_state == HS_WAIT_ACK)
		|| (f_state == HS_WAIT_DROP && fetch_bus.ack);
	assign data_pending = (d_state == HS_IDLE && mem_go) || (d_state == HS_WAIT_ACK)
		|| (d_state == HS_WAIT_DROP && data_bus.ack);
	assign advance = !fetch_pending && !data_pending;  // memory back-pressure

	assign fetch_bus.req   = (f_state == HS_WAIT_ACK);
	assign fetch_bus.we    = 1'b0;
	assign fetch_bus.addr  = pc;  // stable, pc moves only on advance
	assign fetch_bus.wdata = '0;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			f_state  <= HS_IDLE;
			pc       <= '0;
			if_valid <= 1'b0;
		end else begin
			case (f_state)
				HS_IDLE: if (fetch_go) f_state <= HS_WAIT_ACK;
				HS_WAIT_ACK: begin
					if (fetch_bus.ack) begin
						f_state  <= HS_WAIT_DROP;
						if_valid <= 1'b1;
					end
				end
				HS_WAIT_DROP: if (advance) f_state <= HS_IDLE;
				default: f_state <= HS_IDLE;
			endcase
			if (advance && !stall && if_valid) begin  // consumed by IF/ID
				if_valid <= 1'b0;
				pc       <= pc + 16'd1;
			end
		end
	end

	always_ff @(posedge clk)
		if (f_state == HS_WAIT_ACK && fetch_bus.ack)
			if_instr <= fetch_bus.rdata;

	// ************************************************************
	// IF/ID, ID/EX
	// ************************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			if_id_valid <= 1'b0;
			id_ex_valid <= 1'b0;
		end else if (advance) begin
			if (!stall)
				if_id_valid <= if_valid && !hlt_seen;  // HLT turns IF/ID into bubble
			id_ex_valid <= if_id_valid && !stall;      // load-use bubble
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			if (!stall)
				if_id_q <= if_instr;
			id_ex_instr <= if_id_q;
			id_ex_rs    <= rs_data;
			id_ex_rt    <= rt_data;
			id_ex_rd    <= rd_data;
		end
	end

	assign if_id_instr = if_id_valid ? if_id_q : 16'h7000;  // empty reads as nop
	assign rs_idx = if_id_q[7:4];
	assign rt_idx = if_id_q[3:0];
	assign rd_idx = if_id_q[11:8];

	// ************************************************************
	// EX, forwarding and ALU
	// ************************************************************
	assign ex_op      = cpu_pkg::opcode_t'(id_ex_instr[15:12]);
	assign ex_imm     = {{12{id_ex_instr[3]}}, id_ex_instr[3:0]};
	assign ex_mem_fwd = ex_mem_valid && ex_mem_wen && !ex_mem_lw;  // LW waits a stall
	assign mem_wb_fwd = mem_wb_valid && mem_wb_wen;

	always_comb begin
		op_a = id_ex_rs;
		op_b = id_ex_rt;
		op_c = id_ex_rd;
		// older first, EX/MEM overrides
		if (mem_wb_fwd && mem_wb_rd == id_ex_instr[7:4]) op_a = mem_wb_result;
		if (mem_wb_fwd && mem_wb_rd == id_ex_instr[3:0]) op_b = mem_wb_result;
		if (mem_wb_fwd && mem_wb_rd == id_ex_instr[11:8]) op_c = mem_wb_result;
		if (ex_mem_fwd && ex_mem_rd == id_ex_instr[7:4]) op_a = ex_mem_result;
		if (ex_mem_fwd && ex_mem_rd == id_ex_instr[3:0]) op_b = ex_mem_result;
		if (ex_mem_fwd && ex_mem_rd == id_ex_instr[11:8]) op_c = ex_mem_result;
	end

	always_comb begin
		ex_result = op_a + ex_imm;  // LW/SW address
		ex_wen    = 1'b1;
		case (ex_op)
			cpu_pkg::OP_ADD: ex_result = op_a + op_b;
			cpu_pkg::OP_SUB: ex_result = op_a - op_b;
			cpu_pkg::OP_AND: ex_result = op_a & op_b;
			cpu_pkg::OP_OR:  ex_result = op_a | op_b;
			cpu_pkg::OP_XOR: ex_result = op_a ^ op_b;
			cpu_pkg::OP_SLL: ex_result = op_a << op_b[3:0];
			cpu_pkg::OP_SRL: ex_result = op_a >> op_b[3:0];
			cpu_pkg::OP_LHB: ex_result = {id_ex_instr[7:0], op_c[7:0]};
			cpu_pkg::OP_LLB: ex_result = {op_c[15:8], id_ex_instr[7:0]};
			cpu_pkg::OP_LW:  ex_wen = 1'b1;
			default:         ex_wen = 1'b0;  // SW, nops, HLT
		endcase
	end

	// ************************************************************
	// EX/MEM, data requester, MEM/WB
	// ************************************************************
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem_valid <= 1'b0;
			mem_wb_valid <= 1'b0;
		end else if (advance) begin
			ex_mem_valid <= id_ex_valid;
			mem_wb_valid <= ex_mem_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance) begin
			ex_mem_wen    <= ex_wen;
			ex_mem_lw     <= (ex_op == cpu_pkg::OP_LW);
			ex_mem_sw     <= (ex_op == cpu_pkg::OP_SW);
			ex_mem_rd     <= id_ex_instr[11:8];
			ex_mem_result <= ex_result;
			ex_mem_store  <= op_c;  // SW data is rd
			mem_wb_wen    <= ex_mem_wen;
			mem_wb_rd     <= ex_mem_rd;
			mem_wb_result <= ex_mem_lw ? load_q : ex_mem_result;
		end
	end

	assign mem_go         = ex_mem_valid && (ex_mem_lw || ex_mem_sw);
	assign data_bus.req   = (d_state == HS_WAIT_ACK);
	assign data_bus.we    = ex_mem_sw;
	assign data_bus.addr  = ex_mem_result;
	assign data_bus.wdata = ex_mem_store;

	// done access parks in WAIT_DROP until the step
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			d_state <= HS_IDLE;
		end else begin
			case (d_state)
				HS_IDLE: if (mem_go) d_state <= HS_WAIT_ACK;
				HS_WAIT_ACK: if (data_bus.ack) d_state <= HS_WAIT_DROP;
				HS_WAIT_DROP: if (advance) d_state <= HS_IDLE;
				default: d_state <= HS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
		if (d_state == HS_WAIT_ACK && data_bus.ack)
			load_q <= data_bus.rdata;

	// WB, one write per retired instr
	assign wen     = advance && mem_wb_valid && mem_wb_wen;
	assign wr_idx  = mem_wb_rd;
	assign wr_data = mem_wb_result;

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module cpu_top (
	input  logic           clk,
	input  logic           arst_n,
	input  logic           run,        // low holds fetch for host loading
	output logic           halted,
	input  logic           host_req,
	output logic           host_ack,
	input  logic           host_we,
	input  cpu_pkg::addr_t host_addr,
	input  cpu_pkg::word_t host_wdata,
	output cpu_pkg::word_t host_rdata
);

	mem_if fetch_bus ();
	mem_if data_bus ();
	mem_if host_bus ();

	cpu_pkg::reg_idx_t rs_idx, rt_idx, rd_idx;
	cpu_pkg::word_t rs_data, rt_data, rd_data;
	logic wen;
	cpu_pkg::reg_idx_t wr_idx;
	cpu_pkg::word_t wr_data;
	cpu_pkg::word_t if_id_instr, id_ex_instr;
	logic id_ex_valid, advance, stall, hlt_seen;

	// host pins straight onto the bus
	assign host_bus.req   = host_req;
	assign host_bus.we    = host_we;
	assign host_bus.addr  = host_addr;
	assign host_bus.wdata = host_wdata;
	assign host_ack       = host_bus.ack;
	assign host_rdata     = host_bus.rdata;

	cpu_pipeline pipeline0 (.clk, .arst_n, .run, .stall, .hlt_seen,
		.fetch_bus(fetch_bus.requester), .data_bus(data_bus.requester),
		.rs_idx, .rt_idx, .rd_idx, .rs_data, .rt_data, .rd_data,
		.wen, .wr_idx, .wr_data, .if_id_instr, .id_ex_instr, .id_ex_valid, .advance);

	reg_file regs0 (.clk, .arst_n, .rs_idx, .rt_idx, .rd_idx,
		.rs_data, .rt_data, .rd_data, .wen, .wr_idx, .wr_data);

	hazard_detection hazard0 (.clk, .arst_n, .advance, .if_id_instr, .id_ex_instr,
		.id_ex_valid, .stall, .hlt_seen, .halted);

	mem_arbiter arb0 (.clk, .arst_n, .fetch_bus(fetch_bus.responder),
		.data_bus(data_bus.responder), .host_bus(host_bus.responder));

endmodule

`default_nettype wire

/* tests/tb_cpu_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "cpu_settings.svh"

module tb_cpu_top;

	logic           clk;
	logic           arst_n;
	logic           run;
	logic           halted;
	logic           host_req;
	logic           host_ack;
	logic           host_we;
	cpu_pkg::addr_t host_addr;
	cpu_pkg::word_t host_wdata;
	cpu_pkg::word_t host_rdata;

	cpu_pkg::word_t img [`MEM_DEPTH];      // image loaded over the host port
	cpu_pkg::word_t exp_mem [`MEM_DEPTH];  // expected memory contents
	int     plen;                          // next free program word
	integer seed = 58413;
	int     errors = 0;
	int     cycles = 0;
	int     budget = 40;                   // grows as each test is set up

	cpu_top dut0 (.clk, .arst_n, .run, .halted, .host_req, .host_ack, .host_we,
		.host_addr, .host_wdata, .host_rdata);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;  // 10 ns
	end

	// run limit from the work queued so far
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > budget) begin
			$display("timeout: the core or host port stopped responding after %0d cycles", cycles);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ************************************************************
	// random helpers and the ISA model
	// ************************************************************
	function automatic cpu_pkg::word_t rand_word();
		logic [31:0] v;
		v = $random(seed);
		return v[15:0];
	endfunction

	function automatic int rnd(input int n);
		logic [31:0] v;
		v = $random(seed);
		return int'({1'b0, v[30:0]}) % n;  // 0..n-1
	endfunction

	// interpret img until HLT, final memory lands in exp_mem
	function automatic int ref_run();
		cpu_pkg::word_t    r [16];
		cpu_pkg::word_t    ins;
		cpu_pkg::word_t    ea;  // rs + imm4
		cpu_pkg::reg_idx_t rd;
		cpu_pkg::reg_idx_t rs;
		cpu_pkg::reg_idx_t rt;
		logic [`MEM_AW-1:0] pc;
		logic done;
		int n;
		for (int i = 0; i < 16; i++)
			r[i] = '0;  // reset state
		for (int i = 0; i < `MEM_DEPTH; i++)
			exp_mem[i] = img[i];
		pc = '0;
		done = 1'b0;
		n = 0;
		while (!done && n < `MEM_DEPTH) begin
			ins = exp_mem[pc];
			rd = ins[11:8];
			rs = ins[7:4];
			rt = ins[3:0];
			ea = r[rs] + {{12{ins[3]}}, ins[3:0]};
			pc = pc + 1'b1;
			n++;
			case (cpu_pkg::opcode_t'(ins[15:12]))
				cpu_pkg::OP_ADD: r[rd] = r[rs] + r[rt];
				cpu_pkg::OP_SUB: r[rd] = r[rs] - r[rt];
				cpu_pkg::OP_AND: r[rd] = r[rs] & r[rt];
				cpu_pkg::OP_OR:  r[rd] = r[rs] | r[rt];
				cpu_pkg::OP_XOR: r[rd] = r[rs] ^ r[rt];
				cpu_pkg::OP_SLL: r[rd] = r[rs] << r[rt][3:0];
				cpu_pkg::OP_SRL: r[rd] = r[rs] >> r[rt][3:0];
				cpu_pkg::OP_LW:  r[rd] = exp_mem[ea[`MEM_AW-1:0]];  // wraps
				cpu_pkg::OP_SW:  exp_mem[ea[`MEM_AW-1:0]] = r[rd];
				cpu_pkg::OP_LHB: r[rd] = {ins[7:0], r[rd][7:0]};
				cpu_pkg::OP_LLB: r[rd] = {r[rd][15:8], ins[7:0]};
				cpu_pkg::OP_HLT: done = 1'b1;
				default: ;  // 7, 12, 13, 14
			endcase
		end
		return n;
	endfunction

	// ************************************************************
	// program building
	// ************************************************************
	task automatic fill_image();
		for (int i = 0; i < `MEM_DEPTH; i++)
			img[i] = rand_word();  // random background, data and spare code
		plen = 0;
	endtask

	task automatic emit(input cpu_pkg::opcode_t op, input cpu_pkg::reg_idx_t a,
		input cpu_pkg::reg_idx_t b, input cpu_pkg::reg_idx_t c);
		img[plen] = {op, a, b, c};
		plen++;
	endtask

	task automatic emit_imm(input cpu_pkg::opcode_t op, input cpu_pkg::reg_idx_t rd,
		input logic [7:0] imm);
		emit(op, rd, imm[7:4], imm[3:0]);
	endtask

	// back-to-back dependent ALU chain
	task automatic build_forwarding();
		fill_image();
		emit_imm(cpu_pkg::OP_LLB, 4'd1, 8'h80);  // base 128
		emit_imm(cpu_pkg::OP_LHB, 4'd1, 8'h00);
		emit_imm(cpu_pkg::OP_LLB, 4'd2, 8'h34);
		emit_imm(cpu_pkg::OP_LHB, 4'd2, 8'h12);  // rd of the LLB just before
		emit_imm(cpu_pkg::OP_LLB, 4'd3, 8'h03);
		emit(cpu_pkg::OP_ADD, 4'd4, 4'd2, 4'd3);
		emit(cpu_pkg::OP_SUB, 4'd5, 4'd4, 4'd2);
		emit(cpu_pkg::OP_AND, 4'd6, 4'd5, 4'd4);
		emit(cpu_pkg::OP_OR, 4'd7, 4'd6, 4'd2);
		emit(cpu_pkg::OP_XOR, 4'd8, 4'd7, 4'd4);
		emit(cpu_pkg::OP_SLL, 4'd9, 4'd8, 4'd3);  // shift by a register
		emit(cpu_pkg::OP_SRL, 4'd10, 4'd9, 4'd3);
		emit(cpu_pkg::OP_ADD, 4'd10, 4'd10, 4'd10);
		emit(cpu_pkg::OP_SUB, 4'd11, 4'd3, 4'd10);
		for (int i = 4; i < 12; i++)
			emit(cpu_pkg::OP_SW, 4'(i), 4'd1, 4'(i - 4));
		emit(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0);
	endtask

	// loaded value used right away as rs, rt and rd
	task automatic build_load_use();
		fill_image();
		emit_imm(cpu_pkg::OP_LLB, 4'd1, 8'h80);
		emit_imm(cpu_pkg::OP_LHB, 4'd1, 8'h00);
		emit(cpu_pkg::OP_LW, 4'd2, 4'd1, 4'd0);
		emit(cpu_pkg::OP_ADD, 4'd3, 4'd2, 4'd2);
		emit(cpu_pkg::OP_LW, 4'd4, 4'd1, 4'd1);
		emit(cpu_pkg::OP_SUB, 4'd5, 4'd3, 4'd4);  // rt
		emit(cpu_pkg::OP_LW, 4'd6, 4'd1, 4'd2);
		emit(cpu_pkg::OP_SW, 4'd6, 4'd1, 4'd3);   // store data
		emit(cpu_pkg::OP_LW, 4'd7, 4'd1, 4'd3);   // reads the word just stored
		emit_imm(cpu_pkg::OP_LHB, 4'd7, 8'hab);
		emit(cpu_pkg::OP_LW, 4'd8, 4'd1, 4'd4);
		emit_imm(cpu_pkg::OP_LLB, 4'd8, 8'hcd);
		emit(cpu_pkg::OP_SW, 4'd3, 4'd1, 4'd4);
		emit(cpu_pkg::OP_SW, 4'd5, 4'd1, 4'd5);
		emit(cpu_pkg::OP_SW, 4'd7, 4'd1, 4'd6);
		emit(cpu_pkg::OP_SW, 4'd8, 4'd1, 4'd7);
		emit(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0);
	endtask

	// stores after HLT must never happen
	task automatic build_halt();
		fill_image();
		emit_imm(cpu_pkg::OP_LLB, 4'd1, 8'h80);
		emit_imm(cpu_pkg::OP_LHB, 4'd1, 8'h00);
		emit_imm(cpu_pkg::OP_LLB, 4'd2, 8'h5a);
		emit(cpu_pkg::OP_SW, 4'd2, 4'd1, 4'd0);
		emit(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0);
		for (int i = 1; i < 4; i++)
			emit(cpu_pkg::OP_SW, 4'd2, 4'd1, 4'(i));  // markers at 129..131
	endtask

	task automatic build_random();
		int k;
		cpu_pkg::reg_idx_t rd;
		cpu_pkg::reg_idx_t rs;
		cpu_pkg::reg_idx_t rt;
		fill_image();
		emit_imm(cpu_pkg::OP_LLB, 4'd15, 8'h80);  // r15 = 128, only load/store base
		emit_imm(cpu_pkg::OP_LHB, 4'd15, 8'h00);
		repeat (40) begin
			k = rnd(11);
			rd = 4'(rnd(15));  // r0..r14
			rs = 4'(rnd(15));
			rt = 4'(rnd(15));
			if (k < 7)
				emit(cpu_pkg::opcode_t'(4'(k)), rd, rs, rt);
			else if (k == 7)
				emit_imm(cpu_pkg::OP_LHB, rd, 8'(rnd(256)));
			else if (k == 8)
				emit_imm(cpu_pkg::OP_LLB, rd, 8'(rnd(256)));
			else if (k == 9)
				emit(cpu_pkg::OP_LW, rd, 4'd15, 4'(rnd(16)));
			else
				emit(cpu_pkg::OP_SW, rd, 4'd15, 4'(rnd(16)));  // 120..135
		end
		// dump r0..r14 at 240 onward
		emit_imm(cpu_pkg::OP_LLB, 4'd15, 8'hf0);
		for (int i = 0; i < 8; i++)
			emit(cpu_pkg::OP_SW, 4'(i), 4'd15, 4'(i));
		emit_imm(cpu_pkg::OP_LLB, 4'd15, 8'hf8);
		for (int i = 8; i < 15; i++)
			emit(cpu_pkg::OP_SW, 4'(i), 4'd15, 4'(i - 8));
		emit(cpu_pkg::OP_HLT, 4'd0, 4'd0, 4'd0);
	endtask

	// ************************************************************
	// host port and test sequencing
	// ************************************************************
	task automatic host_access(input logic we, input cpu_pkg::addr_t a,
		input cpu_pkg::word_t wd, output cpu_pkg::word_t rd);
		@(posedge clk);
		host_req   <= 1'b1;
		host_we    <= we;
		host_addr  <= a;
		host_wdata <= wd;
		@(negedge clk);
		while (host_ack !== 1'b1)
			@(negedge clk);
		rd = host_rdata;  // valid while ack high
		@(posedge clk);
		host_req <= 1'b0;
		@(negedge clk);
		while (host_ack !== 1'b0)
			@(negedge clk);
	endtask

	task automatic apply_reset();
		budget += 10;
		@(posedge clk);
		arst_n <= 1'b0;
		run    <= 1'b0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
	endtask

	task automatic load_image();
		cpu_pkg::word_t unused;
		for (int i = 0; i < `MEM_DEPTH; i++)
			host_access(1'b1, 16'(i), img[i], unused);
	endtask

	// data region 128..255 against exp_mem
	task automatic check_region(input string name);
		cpu_pkg::word_t got;
		for (int a = 128; a < `MEM_DEPTH; a++) begin
			host_access(1'b0, 16'(a), 16'h0000, got);
			if (got !== exp_mem[a]) begin
				errors++;
				$display("[ERROR] %s: addr %0d expected %h actual %h", name, a, exp_mem[a], got);
			end
		end
	endtask

	task automatic run_program(input string name);
		int n;
		apply_reset();
		n = ref_run();
		budget += 40 * n + 6 * (`MEM_DEPTH + 128) + 20;
		load_image();
		@(posedge clk);
		run <= 1'b1;
		@(negedge clk);
		while (halted !== 1'b1)
			@(negedge clk);
		check_region(name);
		if (halted !== 1'b1) begin  // sticky
			errors++;
			$display("%s: halted went low again before reset", name);
		end
		@(posedge clk);
		run <= 1'b0;
	endtask

	initial begin
		cpu_pkg::word_t got;
		arst_n     = 1'b0;
		run        = 1'b0;
		host_req   = 1'b0;
		host_we    = 1'b0;
		host_addr  = '0;
		host_wdata = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		// host only, core held with run low
		budget += 6 * 256;
		for (int a = 128; a < `MEM_DEPTH; a++) begin
			exp_mem[a] = rand_word();
			host_access(1'b1, 16'(a), exp_mem[a], got);
		end
		check_region("host");

		build_forwarding();
		run_program("forwarding");
		build_load_use();
		run_program("load_use");
		build_halt();
		run_program("halt");

		// host port still served after halt
		budget += 12;
		host_access(1'b1, 16'd200, 16'hc3a5, got);
		host_access(1'b0, 16'd200, 16'h0000, got);
		if (got !== 16'hc3a5) begin
			errors++;
			$display("[ERROR] halt: addr 200 expected c3a5 actual %h", got);
		end
		if (halted !== 1'b1) begin
			errors++;
			$display("halt: halted dropped during the host access after halt");
		end

		for (int p = 0; p < 8; p++) begin
			build_random();
			run_program($sformatf("random%0d", p));
		end

		$display("tests done, errors: %0d", errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hw
hw/cpu_pkg.sv
hw/mem_if.sv
hw/mem_arbiter.sv
hw/reg_file.sv
hw/hazard_detection.sv
hw/cpu_pipeline.sv
hw/cpu_top.sv
tests/tb_cpu_top.sv

/* Makefile */
VERILATOR ?= verilator
FLIST     ?= flist.f
TOP       ?= tb_cpu_top
RTL_TOP   ?= cpu_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_TEXT ?= *** PASSED ***

SOURCES := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all run build lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
